//--- sources.f
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/regFile.sv
rtl/instrDecode.sv
rtl/idExReg.sv
rtl/execStage.sv
rtl/decExTop.sv
dv/decExTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the decode/execute testbench with Verilator and runs it.
set -u

cd "$(dirname "$0")" || exit 1

logFile="sim.log"
simBin="decExTbSim"

verilator --binary --timing --top-module decExTb -f sources.f -o "$simBin"
buildStatus=$?
if [ "$buildStatus" -ne 0 ]; then
	echo "Verilator build failed with status $buildStatus"
	exit 1
fi

./obj_dir/"$simBin" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ "$simStatus" -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "Result: PASSED" "$logFile"; then
	echo "Simulation passed"
	exit 0
fi

echo "Simulation failed, see $logFile"
exit 1

//--- dv/decExTb.sv
`timescale 1ns/1ps
`default_nettype none

module decExTb;

	localparam int clkPeriod = 4;
	localparam int resetCycles = 4;
	localparam int numRows = 32;
	localparam int flushCycles = 4;
	localparam int timeoutNs = (resetCycles + numRows * 3 + flushCycles) * clkPeriod + 40;

	logic clk;
	logic rstN;
	logic instrValid;
	logic [isaPkg::dataW-1:0] instr;
	logic [isaPkg::dataW-1:0] pcAdd2;
	logic wbValid;
	logic [isaPkg::regSelW-1:0] wbReg;
	logic [isaPkg::dataW-1:0] wbData;
	logic [isaPkg::dataW-1:0] wbPcAdd2;
	logic halt;
	logic err;

	// Stimulus and expectation table.
	logic [15:0] rowInstr [numRows];
	logic [15:0] rowPc [numRows];
	logic expValid [numRows];
	logic [2:0] expReg [numRows];
	logic [15:0] expData [numRows];
	logic expHalt [numRows];
	logic expErr [numRows];

	integer seed;
	logic checkEn;
	logic issueValid;
	int issueIdx;
	logic shiftValid [2];	// Follows the 2-cycle latency.
	int shiftIdx [2];
	int curRow;
	int rowsChecked;
	int gap;

	decExTop dut0 (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.pcAdd2(pcAdd2),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.wbPcAdd2(wbPcAdd2),
		.halt(halt),
		.err(err)
	);

	always #(clkPeriod / 2) clk = ~clk;

	function automatic logic [15:0] encodeR(logic [3:0] op, int rd, int rs, int rt);
		return {op, rd[2:0], rs[2:0], rt[2:0], 3'b000};
	endfunction

	function automatic logic [15:0] encodeI(int rd, int rs, logic [5:0] imm);
		return {4'h9, rd[2:0], rs[2:0], imm};
	endfunction

	task automatic setRow(int idx, logic [15:0] ins, int v, int rd, logic [15:0] data, int h,
		int e);
		rowInstr[idx] = ins;
		rowPc[idx] = 16'h0100 + 16'(2 * idx + 2);
		expValid[idx] = v[0];
		expReg[idx] = rd[2:0];
		expData[idx] = data;
		expHalt[idx] = h[0];
		expErr[idx] = e[0];
	endtask

	// Expected values assume all registers start at zero.
	task automatic fillTable();
		setRow(0, encodeR(isaPkg::opAdd, 1, 0, 1), 1, 1, 16'h0000, 0, 0);
		setRow(1, encodeR(isaPkg::opOr, 2, 2, 3), 1, 2, 16'h0000, 0, 0);
		setRow(2, encodeI(1, 4, 6'h05), 1, 1, 16'h0005, 0, 0);
		setRow(3, encodeI(2, 5, 6'h3d), 1, 2, 16'hfffd, 0, 0);	// -3.
		setRow(4, encodeI(3, 6, 6'h1f), 1, 3, 16'h001f, 0, 0);
		setRow(5, encodeI(4, 7, 6'h20), 1, 4, 16'hffe0, 0, 0);	// -32.
		setRow(6, encodeR(isaPkg::opAdd, 5, 1, 2), 1, 5, 16'h0002, 0, 0);	// Wraps.
		setRow(7, encodeR(isaPkg::opSub, 6, 1, 3), 1, 6, 16'hffe6, 0, 0);
		setRow(8, encodeR(isaPkg::opSub, 7, 0, 1), 1, 7, 16'hfffb, 0, 0);
		setRow(9, encodeR(isaPkg::opAnd, 5, 2, 3), 1, 5, 16'h001d, 0, 0);
		setRow(10, encodeR(isaPkg::opOr, 6, 1, 4), 1, 6, 16'hffe5, 0, 0);
		setRow(11, encodeR(isaPkg::opXor, 7, 2, 4), 1, 7, 16'h001d, 0, 0);
		setRow(12, encodeR(isaPkg::opSll, 5, 1, 3), 1, 5, 16'h8000, 0, 0);	// By 15.
		setRow(13, encodeR(isaPkg::opSrl, 6, 4, 1), 1, 6, 16'h07ff, 0, 0);
		setRow(14, encodeR(isaPkg::opSlt, 7, 2, 1), 1, 7, 16'h0001, 0, 0);
		setRow(15, encodeR(isaPkg::opSlt, 7, 1, 2), 1, 7, 16'h0000, 0, 0);
		setRow(16, encodeI(6, 0, 6'h3f), 1, 6, 16'hffff, 0, 0);
		setRow(17, encodeI(7, 0, 6'h01), 1, 7, 16'h0001, 0, 0);
		setRow(18, encodeR(isaPkg::opSlt, 5, 6, 7), 1, 5, 16'h0001, 0, 0);	// -1 < 1.
		setRow(19, encodeI(1, 1, 6'h01), 1, 1, 16'h0006, 0, 0);
		setRow(20, encodeR(isaPkg::opAdd, 1, 1, 1), 1, 1, 16'h000c, 0, 0);
		setRow(21, encodeR(isaPkg::opSub, 2, 1, 7), 1, 2, 16'h000b, 0, 0);
		setRow(22, encodeR(isaPkg::opXor, 3, 2, 1), 1, 3, 16'h0007, 0, 0);
		setRow(23, encodeR(isaPkg::opSll, 4, 3, 3), 1, 4, 16'h0380, 0, 0);
		setRow(24, encodeR(isaPkg::opSrl, 5, 4, 3), 1, 5, 16'h0007, 0, 0);
		setRow(25, encodeR(isaPkg::opSll, 6, 1, 4), 1, 6, 16'h000c, 0, 0);	// Low bits zero.
		setRow(26, encodeR(isaPkg::opNop, 1, 2, 3), 0, 1, 16'h0000, 0, 0);
		setRow(27, encodeR(4'ha, 1, 2, 3), 0, 1, 16'h0000, 0, 1);	// Illegal code.
		setRow(28, encodeR(isaPkg::opAdd, 7, 1, 0), 1, 7, 16'h000c, 0, 0);
		setRow(29, encodeR(isaPkg::opHalt, 2, 0, 0), 0, 2, 16'h0000, 1, 0);
		setRow(30, encodeR(isaPkg::opOr, 2, 5, 6), 1, 2, 16'h000f, 0, 0);
		setRow(31, encodeR(isaPkg::opSub, 3, 0, 3), 1, 3, 16'hfff9, 0, 0);
	endtask

	task automatic checkValue(string name, logic [15:0] expected, logic [15:0] actual);
		if (expected !== actual) begin
			$display("Mismatch at %0t ns: %s expected 0x%h, actual 0x%h", $time, name,
				expected, actual);
			$display("Result: FAILED");
			$fatal(1, "Output check failed");
		end
	endtask

	// One cycle of stimulus. Bubbles carry a random word.
	task automatic issueCycle(logic valid, int idx);
		@(posedge clk);
		shiftValid[1] = shiftValid[0];
		shiftIdx[1] = shiftIdx[0];
		shiftValid[0] = issueValid;
		shiftIdx[0] = issueIdx;
		issueValid = valid;
		issueIdx = idx;
		instrValid <= valid;
		if (valid) begin
			instr <= rowInstr[idx];
			pcAdd2 <= rowPc[idx];
		end else begin
			instr <= 16'($random(seed));
		end
	endtask

	always @(negedge clk) begin
		if (checkEn) begin
			if (shiftValid[1]) begin
				curRow = shiftIdx[1];
				checkValue("wbValid", 16'(expValid[curRow]), 16'(wbValid));
				checkValue("halt", 16'(expHalt[curRow]), 16'(halt));
				checkValue("err", 16'(expErr[curRow]), 16'(err));
				checkValue("wbPcAdd2", rowPc[curRow], wbPcAdd2);
				if (expValid[curRow]) begin
					checkValue("wbReg", 16'(expReg[curRow]), 16'(wbReg));
					checkValue("wbData", expData[curRow], wbData);
				end
				rowsChecked++;
			end else begin
				checkValue("wbValid", 16'h0000, 16'(wbValid));
				checkValue("halt", 16'h0000, 16'(halt));
				checkValue("err", 16'h0000, 16'(err));
			end
		end
	end

	initial begin
		seed = 32'h5ec0;
		clk = 1'b0;
		rstN = 1'b0;
		instrValid = 1'b0;
		instr = '0;
		pcAdd2 = '0;
		checkEn = 1'b0;
		issueValid = 1'b0;
		issueIdx = 0;
		shiftValid[0] = 1'b0;
		shiftValid[1] = 1'b0;
		shiftIdx[0] = 0;
		shiftIdx[1] = 0;
		rowsChecked = 0;
		fillTable();
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
		checkEn = 1'b1;
		for (int i = 0; i < numRows; i++) begin
			gap = $unsigned($random(seed)) % 3;
			repeat (gap) issueCycle(1'b0, 0);
			issueCycle(1'b1, i);
		end
		repeat (flushCycles) issueCycle(1'b0, 0);
		if (rowsChecked != numRows) begin
			$display("Only %0d of %0d table rows reached the outputs", rowsChecked, numRows);
			$display("Result: FAILED");
			$fatal(1, "Row count check failed");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

	initial begin
		#(timeoutNs);
		$display("The run timed out after %0d ns", timeoutNs);
		$display("Result: FAILED");
		$fatal(1, "Watchdog expired");
	end

endmodule

`default_nettype wire

//--- rtl/decExTop.sv
`timescale 1ns/1ps
`default_nettype none

module decExTop (
	input wire logic clk,
	input wire logic rstN,
	input wire logic instrValid,
	input wire logic [isaPkg::dataW-1:0] instr,
	input wire logic [isaPkg::dataW-1:0] pcAdd2,
	output logic wbValid,
	output logic [isaPkg::regSelW-1:0] wbReg,
	output logic [isaPkg::dataW-1:0] wbData,
	output logic [isaPkg::dataW-1:0] wbPcAdd2,
	output logic halt,
	output logic err
);

	logic [ctrlPkg::ctrlW-1:0] ctrl;
	logic [isaPkg::dataW-1:0] pcAdd2Dec;
	logic [isaPkg::regSelW-1:0] rsSel;
	logic [isaPkg::regSelW-1:0] rtSel;
	logic [isaPkg::regSelW-1:0] rdSel;
	logic [isaPkg::dataW-1:0] readData1;
	logic [isaPkg::dataW-1:0] readData2;
	logic [isaPkg::dataW-1:0] immExt;
	logic haltN;
	logic decErr;

	logic [ctrlPkg::ctrlW-1:0] ctrlOut;
	logic [isaPkg::dataW-1:0] pcAdd2Out;
	logic [isaPkg::regSelW-1:0] rsSelOut;
	logic [isaPkg::regSelW-1:0] rtSelOut;
	logic [isaPkg::regSelW-1:0] rdSelOut;
	logic [isaPkg::dataW-1:0] readData1Out;
	logic [isaPkg::dataW-1:0] readData2Out;
	logic [isaPkg::dataW-1:0] immExtOut;
	logic haltNOut;
	logic errOut;

	instrDecode instrDecode0 (
		.clk(clk),
		.rstN(rstN),
		.instrValid(instrValid),
		.instr(instr),
		.pcAdd2In(pcAdd2),
		.wbValid(wbValid),	// Write-back loop.
		.wbReg(wbReg),
		.wbData(wbData),
		.ctrl(ctrl),
		.pcAdd2(pcAdd2Dec),
		.rsSel(rsSel),
		.rtSel(rtSel),
		.rdSel(rdSel),
		.readData1(readData1),
		.readData2(readData2),
		.immExt(immExt),
		.haltN(haltN),
		.decErr(decErr)
	);

	idExReg idExReg0 (
		.clk(clk),
		.rstN(rstN),
		.ctrlIn(ctrl),
		.pcAdd2In(pcAdd2Dec),
		.rsSelIn(rsSel),
		.rtSelIn(rtSel),
		.rdSelIn(rdSel),
		.readData1In(readData1),
		.readData2In(readData2),
		.immExtIn(immExt),
		.haltNIn(haltN),
		.errIn(decErr),
		.ctrlOut(ctrlOut),
		.pcAdd2Out(pcAdd2Out),
		.rsSelOut(rsSelOut),
		.rtSelOut(rtSelOut),
		.rdSelOut(rdSelOut),
		.readData1Out(readData1Out),
		.readData2Out(readData2Out),
		.immExtOut(immExtOut),
		.haltNOut(haltNOut),
		.errOut(errOut)
	);

	execStage execStage0 (
		.clk(clk),
		.rstN(rstN),
		.ctrl(ctrlOut),
		.pcAdd2In(pcAdd2Out),
		.rsSel(rsSelOut),
		.rtSel(rtSelOut),
		.rdSel(rdSelOut),
		.readData1(readData1Out),
		.readData2(readData2Out),
		.immExt(immExtOut),
		.haltN(haltNOut),
		.errIn(errOut),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.wbPcAdd2(wbPcAdd2),
		.halt(halt),
		.err(err)
	);

endmodule

`default_nettype wire

//--- rtl/execStage.sv
`timescale 1ns/1ps
`default_nettype none

module execStage (
	input wire logic clk,
	input wire logic rstN,
	input wire logic [ctrlPkg::ctrlW-1:0] ctrl,
	input wire logic [isaPkg::dataW-1:0] pcAdd2In,
	input wire logic [isaPkg::regSelW-1:0] rsSel,
	input wire logic [isaPkg::regSelW-1:0] rtSel,
	input wire logic [isaPkg::regSelW-1:0] rdSel,
	input wire logic [isaPkg::dataW-1:0] readData1,
	input wire logic [isaPkg::dataW-1:0] readData2,
	input wire logic [isaPkg::dataW-1:0] immExt,
	input wire logic haltN,
	input wire logic errIn,
	output logic wbValid,
	output logic [isaPkg::regSelW-1:0] wbReg,
	output logic [isaPkg::dataW-1:0] wbData,
	output logic [isaPkg::dataW-1:0] wbPcAdd2,
	output logic halt,
	output logic err
);

	ctrlPkg::aluOpT aluOp;
	logic [isaPkg::dataW-1:0] opA;
	logic [isaPkg::dataW-1:0] fwdB;
	logic [isaPkg::dataW-1:0] opB;
	logic [isaPkg::dataW-1:0] aluResult;
	logic [ctrlPkg::shamtW-1:0] shamt;
	logic sltBit;

	assign aluOp = ctrlPkg::aluOpT'(ctrl[ctrlPkg::aluCtrlHi:ctrlPkg::aluCtrlLo]);

	// Forward the previous result to a back-to-back reader.
	assign opA = (wbValid && (wbReg == rsSel)) ? wbData : readData1;
	assign fwdB = (wbValid && (wbReg == rtSel)) ? wbData : readData2;
	assign opB = ctrl[ctrlPkg::aluSrc2Bit] ? immExt : fwdB;

	assign shamt = opB[ctrlPkg::shamtW-1:0];
	assign sltBit = $signed(opA) < $signed(opB);

	always_comb begin
		case (aluOp)
			ctrlPkg::aluAdd: aluResult = opA + opB;
			ctrlPkg::aluSub: aluResult = opA - opB;
			ctrlPkg::aluAnd: aluResult = opA & opB;
			ctrlPkg::aluOr: aluResult = opA | opB;
			ctrlPkg::aluXor: aluResult = opA ^ opB;
			ctrlPkg::aluSll: aluResult = opA << shamt;
			ctrlPkg::aluSrl: aluResult = opA >> shamt;
			ctrlPkg::aluSlt: aluResult = {{(isaPkg::dataW - 1){1'b0}}, sltBit};
			default: aluResult = opA + opB;
		endcase
	end

	// EX/WB register.
	always_ff @(posedge clk) begin
		if (!rstN) begin
			wbValid <= 1'b0;
			halt <= 1'b0;
			err <= 1'b0;
		end else begin
			wbValid <= ctrl[ctrlPkg::regWriteBit];
			halt <= ~haltN;
			err <= errIn;
		end
	end

	always_ff @(posedge clk) begin
		wbReg <= rdSel;
		wbData <= aluResult;
		wbPcAdd2 <= pcAdd2In;	// Kept for a later link step.
	end

endmodule

`default_nettype wire

//--- rtl/idExReg.sv
`timescale 1ns/1ps
`default_nettype none

module idExReg (
	input wire logic clk,
	input wire logic rstN,
	input wire logic [ctrlPkg::ctrlW-1:0] ctrlIn,
	input wire logic [isaPkg::dataW-1:0] pcAdd2In,
	input wire logic [isaPkg::regSelW-1:0] rsSelIn,
	input wire logic [isaPkg::regSelW-1:0] rtSelIn,
	input wire logic [isaPkg::regSelW-1:0] rdSelIn,
	input wire logic [isaPkg::dataW-1:0] readData1In,
	input wire logic [isaPkg::dataW-1:0] readData2In,
	input wire logic [isaPkg::dataW-1:0] immExtIn,
	input wire logic haltNIn,
	input wire logic errIn,
	output logic [ctrlPkg::ctrlW-1:0] ctrlOut,
	output logic [isaPkg::dataW-1:0] pcAdd2Out,
	output logic [isaPkg::regSelW-1:0] rsSelOut,
	output logic [isaPkg::regSelW-1:0] rtSelOut,
	output logic [isaPkg::regSelW-1:0] rdSelOut,
	output logic [isaPkg::dataW-1:0] readData1Out,
	output logic [isaPkg::dataW-1:0] readData2Out,
	output logic [isaPkg::dataW-1:0] immExtOut,
	output logic haltNOut,
	output logic errOut
);

	logic [ctrlPkg::ctrlW-1:0] ctrlMasked;

	// No write for errored or halting instructions.
	always_comb begin
		ctrlMasked = ctrlIn;
		ctrlMasked[ctrlPkg::regWriteBit] = ctrlIn[ctrlPkg::regWriteBit] & haltNIn & ~errIn;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ctrlOut <= '0;
			haltNOut <= 1'b1;
			errOut <= 1'b0;
		end else begin
			ctrlOut <= ctrlMasked;
			haltNOut <= haltNIn;
			errOut <= errIn;
		end
	end

	always_ff @(posedge clk) begin
		pcAdd2Out <= pcAdd2In;
		rsSelOut <= rsSelIn;
		rtSelOut <= rtSelIn;
		rdSelOut <= rdSelIn;
		readData1Out <= readData1In;
		readData2Out <= readData2In;
		immExtOut <= immExtIn;
	end

endmodule

`default_nettype wire

//--- rtl/instrDecode.sv
`timescale 1ns/1ps
`default_nettype none

module instrDecode (
	input wire logic clk,
	input wire logic rstN,
	input wire logic instrValid,
	input wire logic [isaPkg::dataW-1:0] instr,
	input wire logic [isaPkg::dataW-1:0] pcAdd2In,
	input wire logic wbValid,
	input wire logic [isaPkg::regSelW-1:0] wbReg,
	input wire logic [isaPkg::dataW-1:0] wbData,
	output logic [ctrlPkg::ctrlW-1:0] ctrl,
	output logic [isaPkg::dataW-1:0] pcAdd2,
	output logic [isaPkg::regSelW-1:0] rsSel,
	output logic [isaPkg::regSelW-1:0] rtSel,
	output logic [isaPkg::regSelW-1:0] rdSel,
	output logic [isaPkg::dataW-1:0] readData1,
	output logic [isaPkg::dataW-1:0] readData2,
	output logic [isaPkg::dataW-1:0] immExt,
	output logic haltN,
	output logic decErr
);

	isaPkg::opcodeT opcode;
	ctrlPkg::aluOpT aluOp;
	logic aluSrc2;
	logic regWrite;

	assign opcode = isaPkg::opcodeT'(instr[isaPkg::opcodeHi:isaPkg::opcodeLo]);
	assign rdSel = instr[isaPkg::rdHi:isaPkg::rdLo];
	assign rsSel = instr[isaPkg::rsHi:isaPkg::rsLo];
	assign rtSel = instr[isaPkg::rtHi:isaPkg::rtLo];
	assign pcAdd2 = pcAdd2In;

	assign immExt = {{(isaPkg::dataW - isaPkg::immW){instr[isaPkg::immHi]}},
		instr[isaPkg::immHi:isaPkg::immLo]};	// Sign-extend imm6.

	always_comb begin
		aluOp = ctrlPkg::aluAdd;
		aluSrc2 = 1'b0;
		regWrite = 1'b1;
		haltN = 1'b1;
		decErr = 1'b0;
		case (opcode)
			isaPkg::opNop: regWrite = 1'b0;
			isaPkg::opAdd: aluOp = ctrlPkg::aluAdd;
			isaPkg::opSub: aluOp = ctrlPkg::aluSub;
			isaPkg::opAnd: aluOp = ctrlPkg::aluAnd;
			isaPkg::opOr: aluOp = ctrlPkg::aluOr;
			isaPkg::opXor: aluOp = ctrlPkg::aluXor;
			isaPkg::opSll: aluOp = ctrlPkg::aluSll;
			isaPkg::opSrl: aluOp = ctrlPkg::aluSrl;
			isaPkg::opSlt: aluOp = ctrlPkg::aluSlt;
			isaPkg::opAddi: aluSrc2 = 1'b1;
			isaPkg::opHalt: begin
				regWrite = 1'b0;
				haltN = 1'b0;
			end
			default: begin
				regWrite = 1'b0;
				decErr = 1'b1;
			end
		endcase
		// Bubble.
		if (!instrValid) begin
			aluOp = ctrlPkg::aluAdd;
			aluSrc2 = 1'b0;
			regWrite = 1'b0;
			haltN = 1'b1;
			decErr = 1'b0;
		end
	end

	always_comb begin
		ctrl = '0;
		ctrl[ctrlPkg::aluSrc2Bit] = aluSrc2;
		ctrl[ctrlPkg::aluCtrlHi:ctrlPkg::aluCtrlLo] = aluOp;
		ctrl[ctrlPkg::regWriteBit] = regWrite;
	end

	regFile regFile0 (
		.clk(clk),
		.rstN(rstN),
		.readSel1(rsSel),
		.readSel2(rtSel),
		.readData1(readData1),
		.readData2(readData2),
		.writeEn(wbValid),
		.writeSel(wbReg),
		.writeData(wbData)
	);

endmodule

`default_nettype wire

//--- rtl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
	input wire logic clk,
	input wire logic rstN,
	input wire logic [isaPkg::regSelW-1:0] readSel1,
	input wire logic [isaPkg::regSelW-1:0] readSel2,
	output logic [isaPkg::dataW-1:0] readData1,
	output logic [isaPkg::dataW-1:0] readData2,
	input wire logic writeEn,
	input wire logic [isaPkg::regSelW-1:0] writeSel,
	input wire logic [isaPkg::dataW-1:0] writeData
);

	logic [isaPkg::dataW-1:0] regs [isaPkg::numRegs];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 0; i < isaPkg::numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn) begin
			regs[writeSel] <= writeData;
		end
	end

	// Write-through so a same-cycle reader sees the new value.
	always_comb begin
		if (writeEn && (writeSel == readSel1)) begin
			readData1 = writeData;
		end else begin
			readData1 = regs[readSel1];
		end
		if (writeEn && (writeSel == readSel2)) begin
			readData2 = writeData;
		end else begin
			readData2 = regs[readSel2];
		end
	end

endmodule

`default_nettype wire

//--- rtl/ctrlPkg.sv
`default_nettype none

package ctrlPkg;

	localparam int aluOpW = 4;
	localparam int shamtW = 4;	// Shift uses the low bits of B.

	typedef enum logic [aluOpW-1:0] {
		aluAdd = 4'h0,
		aluSub = 4'h1,
		aluAnd = 4'h2,
		aluOr = 4'h3,
		aluXor = 4'h4,
		aluSll = 4'h5,
		aluSrl = 4'h6,
		aluSlt = 4'h7
	} aluOpT;

	// Packed control word layout.
	localparam int ctrlW = 6;
	localparam int aluSrc2Bit = 5;	// Immediate as operand B.
	localparam int aluCtrlHi = 4;
	localparam int aluCtrlLo = 1;
	localparam int regWriteBit = 0;

endpackage

`default_nettype wire

//--- rtl/isaPkg.sv
`default_nettype none

package isaPkg;

	localparam int dataW = 16;
	localparam int regSelW = 3;
	localparam int numRegs = 8;
	localparam int opcodeW = 4;
	localparam int immW = 6;

	// Instruction field positions.
	localparam int opcodeHi = 15;
	localparam int opcodeLo = 12;
	localparam int rdHi = 11;
	localparam int rdLo = 9;
	localparam int rsHi = 8;
	localparam int rsLo = 6;
	localparam int rtHi = 5;
	localparam int rtLo = 3;
	localparam int immHi = 5;
	localparam int immLo = 0;

	typedef enum logic [opcodeW-1:0] {
		opNop = 4'h0,
		opAdd = 4'h1,
		opSub = 4'h2,
		opAnd = 4'h3,
		opOr = 4'h4,
		opXor = 4'h5,
		opSll = 4'h6,
		opSrl = 4'h7,
		opSlt = 4'h8,
		opAddi = 4'h9,
		opHalt = 4'hF	// Codes 4'hA to 4'hE are illegal.
	} opcodeT;

endpackage

`default_nettype wire
